//--- Makefile
# Verilator build and run for upper_core

VERILATOR ?= verilator
TOP       ?= upper_core_tb
RTL_TOP   ?= upper_core
FILELIST  ?= upper_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

PASS_TEXT := all tests passed
SOURCES   := $(wildcard hdl/*.sv bench/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/upper_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module upper_core_tb;

    localparam int CLK_HALF = 5;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_OP = 200;
    // Driven at one edge, seen by the cache at the next, ack sampled at the one after
    localparam int HIT_LATENCY = 2;
    localparam logic [15:0] INIT_XOR = 16'h5a5a;

    localparam int K_FETCH = 0;
    localparam int K_LOAD = 1;
    localparam int K_STORE = 2;
    localparam int K_BOTH = 3;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        fetch_req;
    logic [15:0] fetch_addr;
    logic [31:0] fetch_data;
    logic        fetch_ack;
    logic        data_req;
    logic        data_we;
    logic [15:0] data_addr;
    logic [15:0] data_wdata;
    logic [15:0] data_rdata;
    logic        data_ack;
    logic        data_err;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [23:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic [1:0]  wb_sel;
    logic        wb_ack;
    logic        wb_err;
    logic        wb_rty;

    // One operation table entry per index across these queues
    string       op_name[$];
    int          op_kind[$];
    logic [15:0] op_faddr[$];
    logic [15:0] op_daddr[$];
    logic [15:0] op_wdata[$];
    logic [31:0] op_inst[$];
    logic [15:0] op_word[$];
    logic        op_err[$];
    int          op_bus[$];
    logic [15:0] shadow [logic [15:0]];

    int          n_ops = 0;
    int          pass_count;
    int          fail_count;
    logic        test_ok;
    logic        cyc_prev;
    int          rise_count;
    logic [23:0] start_adr [256];

    always #CLK_HALF clk = ~clk;

    upper_core DUT (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .i_fetch_req  (fetch_req),
        .i_fetch_addr (fetch_addr),
        .o_fetch_data (fetch_data),
        .o_fetch_ack  (fetch_ack),
        .i_data_req   (data_req),
        .i_data_we    (data_we),
        .i_data_addr  (data_addr),
        .i_data_wdata (data_wdata),
        .o_data_rdata (data_rdata),
        .o_data_ack   (data_ack),
        .o_data_err   (data_err),
        .o_wb_cyc     (wb_cyc),
        .o_wb_stb     (wb_stb),
        .o_wb_we      (wb_we),
        .o_wb_adr     (wb_adr),
        .o_wb_dat     (wb_dat_w),
        .o_wb_sel     (wb_sel),
        .i_wb_dat     (wb_dat_r),
        .i_wb_ack     (wb_ack),
        .i_wb_err     (wb_err),
        .i_wb_rty     (wb_rty)
    );

    wb_mem_model mem (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .i_wb_sel (wb_sel),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack),
        .o_wb_err (wb_err),
        .o_wb_rty (wb_rty)
    );

    // Counts cyc rising edges and keeps the address of each
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc_prev <= 1'b0;
            rise_count <= 0;
        end else begin
            cyc_prev <= wb_cyc;
            if (wb_cyc && !cyc_prev) begin
                rise_count <= rise_count + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arst_n && wb_cyc && !cyc_prev) begin
            start_adr[rise_count[7:0]] <= wb_adr;
        end
    end

    function automatic logic [15:0] init_word(input logic [15:0] a);
        return a ^ INIT_XOR;
    endfunction

    function automatic logic [15:0] stored_word(input logic [15:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    task automatic add_op(input string name, input int kind, input logic [15:0] faddr,
                          input logic [15:0] daddr, input logic [15:0] wdata,
                          input logic exp_err, input int nbus);
        logic [31:0] inst;
        logic [15:0] word;
        inst = {init_word(faddr + 16'd1), init_word(faddr)};
        word = stored_word(daddr);
        if (kind == K_STORE) begin
            shadow[daddr] = wdata;
        end
        op_name.push_back(name);
        op_kind.push_back(kind);
        op_faddr.push_back(faddr);
        op_daddr.push_back(daddr);
        op_wdata.push_back(wdata);
        op_inst.push_back(inst);
        op_word.push_back(word);
        op_err.push_back(exp_err);
        op_bus.push_back(nbus);
    endtask

    task automatic build_table();
        add_op("fetch_miss", K_FETCH, 16'h0040, 16'h0000, 16'h0000, 1'b0, 2);
        add_op("fetch_hit", K_FETCH, 16'h0040, 16'h0000, 16'h0000, 1'b0, 0);
        add_op("fetch_conflict", K_FETCH, 16'h0060, 16'h0000, 16'h0000, 1'b0, 2);
        add_op("conflict_hit", K_FETCH, 16'h0060, 16'h0000, 16'h0000, 1'b0, 0);
        add_op("fetch_evicted", K_FETCH, 16'h0040, 16'h0000, 16'h0000, 1'b0, 2);
        add_op("store_word", K_STORE, 16'h0000, 16'h0200, 16'hbeef, 1'b0, 1);
        add_op("load_stored", K_LOAD, 16'h0000, 16'h0200, 16'h0000, 1'b0, 1);
        add_op("load_initial", K_LOAD, 16'h0000, 16'h0201, 16'h0000, 1'b0, 1);
        add_op("fetch_with_load", K_BOTH, 16'h0108, 16'h0200, 16'h0000, 1'b0, 3);
        add_op("hit_after_both", K_FETCH, 16'h0108, 16'h0000, 16'h0000, 1'b0, 0);
        add_op("load_retry", K_LOAD, 16'h0000, 16'h0f00, 16'h0000, 1'b0, 1);
        add_op("store_retry_addr", K_STORE, 16'h0000, 16'h0f00, 16'h1234, 1'b0, 1);
        add_op("load_retry_addr", K_LOAD, 16'h0000, 16'h0f00, 16'h0000, 1'b0, 1);
        add_op("load_bus_error", K_LOAD, 16'h0000, 16'h0f02, 16'h0000, 1'b1, 1);
    endtask

    task automatic check_equal(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("error %s %s: expected %h, actual %h", name, what, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic run_op(input int i);
        int          lat;
        int          rises_before;
        logic        f_wait;
        logic        d_wait;
        logic [31:0] got_inst;
        logic [15:0] got_word;
        logic        got_err;
        lat = 0;
        test_ok = 1'b1;
        got_inst = '0;
        got_word = '0;
        got_err = 1'b0;
        f_wait = (op_kind[i] == K_FETCH) || (op_kind[i] == K_BOTH);
        d_wait = (op_kind[i] != K_FETCH);
        @(posedge clk);
        rises_before = rise_count;
        if (f_wait) begin
            fetch_req <= 1'b1;
            fetch_addr <= op_faddr[i];
        end
        if (d_wait) begin
            data_req <= 1'b1;
            data_we <= (op_kind[i] == K_STORE);
            data_addr <= op_daddr[i];
            data_wdata <= op_wdata[i];
        end
        while (f_wait || d_wait) begin
            @(posedge clk);
            lat++;
            // Every strobe carries all byte selects
            if (wb_stb) begin
                check_equal(op_name[i], "bus select", 32'(2'b11), 32'(wb_sel));
            end
            if (f_wait && fetch_ack) begin
                got_inst = fetch_data;
                f_wait = 1'b0;
                fetch_req <= 1'b0;
                if (op_kind[i] == K_FETCH && op_bus[i] == 0) begin
                    check_equal(op_name[i], "hit latency", HIT_LATENCY, lat);
                end
            end
            if (d_wait && data_ack) begin
                got_word = data_rdata;
                got_err = data_err;
                d_wait = 1'b0;
                data_req <= 1'b0;
                data_we <= 1'b0;
            end
        end
        check_equal(op_name[i], "bus cycles", op_bus[i], rise_count - rises_before);
        if (op_kind[i] == K_FETCH || op_kind[i] == K_BOTH) begin
            check_equal(op_name[i], "instruction", op_inst[i], got_inst);
        end
        if (op_kind[i] != K_FETCH) begin
            check_equal(op_name[i], "data err", 32'(op_err[i]), 32'(got_err));
        end
        if ((op_kind[i] == K_LOAD || op_kind[i] == K_BOTH) && !op_err[i]) begin
            check_equal(op_name[i], "load data", 32'(op_word[i]), 32'(got_word));
        end
        // Data has priority, so its address opens the first bus cycle
        if (op_kind[i] == K_BOTH) begin
            check_equal(op_name[i], "first bus address", 32'({8'h00, op_daddr[i]}),
                        32'(start_adr[rises_before[7:0]]));
        end
        if (test_ok) begin
            pass_count++;
            $display("%s: ok", op_name[i]);
        end else begin
            fail_count++;
            $display("%s: FAILED", op_name[i]);
        end
    endtask

    initial begin
        wait (n_ops > 0);
        repeat (RESET_CYCLES + n_ops * CYCLES_PER_OP) @(posedge clk);
        $display("timeout: the operation table did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = 16'h0000;
        data_req = 1'b0;
        data_we = 1'b0;
        data_addr = 16'h0000;
        data_wdata = 16'h0000;
        pass_count = 0;
        fail_count = 0;
        build_table();
        n_ops = op_name.size();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        $display("summary: %0d of %0d passed, %0d with errors", pass_count, n_ops, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/wb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_model (
    input  wire          i_clk,
    input  wire          i_arst_n,
    input  wire          i_wb_cyc,
    input  wire          i_wb_stb,
    input  wire          i_wb_we,
    input  wire  [23:0]  i_wb_adr,
    input  wire  [15:0]  i_wb_dat,
    input  wire  [1:0]   i_wb_sel,
    output logic [15:0]  o_wb_dat,
    output logic         o_wb_ack,
    output logic         o_wb_err,
    output logic         o_wb_rty
);

    localparam logic [31:0] LFSR_SEED = 32'ha40c;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam logic [23:0] RTY_ADR = 24'h000f00;
    localparam logic [23:0] ERR_ADR = 24'h000f02;

    logic [15:0] ram [4096];
    logic [31:0] lfsr;
    logic [31:0] lfsr_mid;
    logic [1:0]  draw;
    logic [1:0]  wait_left;
    logic        busy;
    logic        rty_seen;
    logic        request;
    logic        fire;
    logic        plain;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            ram[i[11:0]] = i[15:0] ^ 16'h5a5a;
        end
    end

    // Two LFSR steps give the two bits of the wait count
    assign lfsr_mid = lfsr_next(lfsr);
    assign draw = {lfsr_mid[0], lfsr[0]};

    // A new strobe is only taken once the previous response is gone
    assign request = i_wb_cyc && i_wb_stb && !(o_wb_ack || o_wb_err || o_wb_rty);
    assign fire = request && (busy ? (wait_left == 2'd0) : (draw == 2'd0));
    assign plain = !(i_wb_adr == RTY_ADR && !rty_seen) && (i_wb_adr != ERR_ADR);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lfsr <= LFSR_SEED;
            busy <= 1'b0;
            wait_left <= 2'd0;
            rty_seen <= 1'b0;
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            o_wb_rty <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            o_wb_rty <= 1'b0;
            if (request && !busy) begin
                lfsr <= lfsr_next(lfsr_mid);
            end
            if (fire) begin
                busy <= 1'b0;
                if (i_wb_adr == RTY_ADR && !rty_seen) begin
                    o_wb_rty <= 1'b1;
                    rty_seen <= 1'b1;
                end else if (i_wb_adr == ERR_ADR) begin
                    o_wb_err <= 1'b1;
                end else begin
                    o_wb_ack <= 1'b1;
                end
            end else if (request && !busy) begin
                busy <= 1'b1;
                wait_left <= draw - 2'd1;
            end else if (request) begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    // Byte lanes are written only where their select bit is high
    always_ff @(posedge i_clk) begin
        if (fire && plain) begin
            if (i_wb_we && i_wb_sel[0]) begin
                ram[i_wb_adr[11:0]][7:0] <= i_wb_dat[7:0];
            end
            if (i_wb_we && i_wb_sel[1]) begin
                ram[i_wb_adr[11:0]][15:8] <= i_wb_dat[15:8];
            end
            o_wb_dat <= ram[i_wb_adr[11:0]];
        end
    end

endmodule

`default_nettype wire

//--- hdl/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache (
    input  wire                              i_clk,
    input  wire                              i_arst_n,

    input  wire                              i_fetch_req,
    input  wire  [mem_pkg::RW-1:0]           i_fetch_addr,
    output logic [mem_pkg::I_SIZE-1:0]       o_fetch_data,
    output logic                             o_fetch_ack,

    output logic                             o_wb_cyc,
    output logic                             o_wb_stb,
    output logic                             o_wb_we,
    output logic [mem_pkg::WB_ADDR_W-1:0]    o_wb_adr,
    output logic [mem_pkg::WB_SEL_BITS-1:0]  o_wb_sel,
    input  wire                              i_wb_ack,
    input  wire  [mem_pkg::WB_DATA_W-1:0]    i_wb_dat
);

    logic [mem_pkg::IC_ST_W-1:0]    state;
    logic [mem_pkg::IC_LINES-1:0]   line_valid;
    logic [mem_pkg::IC_TAG_W-1:0]   line_tag [mem_pkg::IC_LINES];
    logic [mem_pkg::I_SIZE-1:0]     line_data [mem_pkg::IC_LINES];
    logic [mem_pkg::WB_DATA_W-1:0]  lo_word;

    logic [mem_pkg::IC_INDEX_W-1:0] idx;
    logic [mem_pkg::IC_TAG_W-1:0]   req_tag;
    logic                           hit;
    logic                           start;
    logic                           lo_done;
    logic                           hi_done;

    // Each instruction spans two bus words, so bit 0 never selects a line
    assign idx = i_fetch_addr[mem_pkg::IC_INDEX_W:1];
    assign req_tag = {i_fetch_addr[mem_pkg::RW-1:mem_pkg::IC_INDEX_W+1], i_fetch_addr[0]};
    assign hit = line_valid[idx] && (line_tag[idx] == req_tag);

    // No new lookup in the cycle of an ack, the core still holds the old request
    assign start = (state == mem_pkg::IC_IDLE) && i_fetch_req && !o_fetch_ack;
    assign lo_done = (state == mem_pkg::IC_RD_LO) && i_wb_ack;
    assign hi_done = (state == mem_pkg::IC_RD_HI) && i_wb_ack;

    // Instruction fetch only reads
    assign o_wb_we = 1'b0;
    assign o_wb_sel = {mem_pkg::WB_SEL_BITS{1'b1}};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= mem_pkg::IC_IDLE;
            line_valid <= '0;
            o_fetch_ack <= 1'b0;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
        end else begin
            o_fetch_ack <= 1'b0;
            case (state)
                mem_pkg::IC_IDLE: begin
                    if (start && hit) begin
                        o_fetch_ack <= 1'b1;
                    end else if (start) begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        state <= mem_pkg::IC_RD_LO;
                    end
                end
                mem_pkg::IC_RD_LO: begin
                    // End this bus cycle, the high word gets a cycle of its own
                    if (lo_done) begin
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        state <= mem_pkg::IC_GAP;
                    end
                end
                mem_pkg::IC_GAP: begin
                    o_wb_cyc <= 1'b1;
                    o_wb_stb <= 1'b1;
                    state <= mem_pkg::IC_RD_HI;
                end
                default: begin
                    if (hi_done) begin
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        line_valid[idx] <= 1'b1;
                        o_fetch_ack <= 1'b1;
                        state <= mem_pkg::IC_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (start && !hit) begin
            o_wb_adr <= {{mem_pkg::WB_ADDR_PAD{1'b0}}, i_fetch_addr};
        end
        if (state == mem_pkg::IC_GAP) begin
            o_wb_adr <= {{mem_pkg::WB_ADDR_PAD{1'b0}}, i_fetch_addr[mem_pkg::RW-1:1], 1'b1};
        end
        if (lo_done) begin
            lo_word <= i_wb_dat;
        end
        if (start && hit) begin
            o_fetch_data <= line_data[idx];
        end
        if (hi_done) begin
            o_fetch_data <= {i_wb_dat, lo_word};
            line_data[idx] <= {i_wb_dat, lo_word};
            line_tag[idx] <= req_tag;
        end
    end

    // The core needs a cycle to see the ack and move on
    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_fetch_ack |=> !o_fetch_ack);

    // The refill takes its line index and high word address from the held request
    a_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (state != mem_pkg::IC_IDLE) |-> (i_fetch_req && $stable(i_fetch_addr)));

endmodule

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Core side
    localparam int RW = 16;
    localparam int I_SIZE = 32;

    // Wishbone master port
    localparam int WB_DATA_W = 16;
    localparam int WB_ADDR_W = 24;
    localparam int WB_SEL_BITS = 2;

    // Zero bits above a core address to form a bus address
    localparam int WB_ADDR_PAD = WB_ADDR_W - RW;

    // Instruction cache geometry, one instruction per line
    localparam int IC_LINES = 16;
    localparam int IC_INDEX_W = $clog2(IC_LINES);
    localparam int IC_TAG_W = RW - IC_INDEX_W;

    // Refill FSM of the instruction cache
    localparam int IC_ST_W = 2;
    localparam logic [IC_ST_W-1:0] IC_IDLE = 2'd0;
    localparam logic [IC_ST_W-1:0] IC_RD_LO = 2'd1;
    localparam logic [IC_ST_W-1:0] IC_GAP = 2'd2;
    localparam logic [IC_ST_W-1:0] IC_RD_HI = 2'd3;

endpackage

`default_nettype wire

//--- hdl/upper_core.sv
`timescale 1ns/100ps
`default_nettype none

module upper_core (
    input  wire                              i_clk,
    input  wire                              i_arst_n,

    input  wire                              i_fetch_req,
    input  wire  [mem_pkg::RW-1:0]           i_fetch_addr,
    output logic [mem_pkg::I_SIZE-1:0]       o_fetch_data,
    output logic                             o_fetch_ack,

    input  wire                              i_data_req,
    input  wire                              i_data_we,
    input  wire  [mem_pkg::RW-1:0]           i_data_addr,
    input  wire  [mem_pkg::RW-1:0]           i_data_wdata,
    output logic [mem_pkg::RW-1:0]           o_data_rdata,
    output logic                             o_data_ack,
    output logic                             o_data_err,

    output logic                             o_wb_cyc,
    output logic                             o_wb_stb,
    output logic                             o_wb_we,
    output logic [mem_pkg::WB_ADDR_W-1:0]    o_wb_adr,
    output logic [mem_pkg::WB_DATA_W-1:0]    o_wb_dat,
    output logic [mem_pkg::WB_SEL_BITS-1:0]  o_wb_sel,
    input  wire  [mem_pkg::WB_DATA_W-1:0]    i_wb_dat,
    input  wire                              i_wb_ack,
    input  wire                              i_wb_err,
    input  wire                              i_wb_rty
);

    logic                            data_wb_cyc;
    logic                            data_wb_stb;
    logic                            data_wb_we;
    logic [mem_pkg::WB_ADDR_W-1:0]   data_wb_adr;
    logic [mem_pkg::WB_DATA_W-1:0]   data_wb_dat;
    logic [mem_pkg::WB_SEL_BITS-1:0] data_wb_sel;
    logic                            data_wb_ack;
    logic                            data_wb_err;
    logic                            data_wb_rty;

    logic                            fetch_wb_cyc;
    logic                            fetch_wb_stb;
    logic                            fetch_wb_we;
    logic [mem_pkg::WB_ADDR_W-1:0]   fetch_wb_adr;
    logic [mem_pkg::WB_SEL_BITS-1:0] fetch_wb_sel;
    logic                            fetch_wb_ack;

    wb_data_master data_wbm (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_data_req   (i_data_req),
        .i_data_we    (i_data_we),
        .i_data_addr  (i_data_addr),
        .i_data_wdata (i_data_wdata),
        .o_data_rdata (o_data_rdata),
        .o_data_ack   (o_data_ack),
        .o_data_err   (o_data_err),
        .o_wb_cyc     (data_wb_cyc),
        .o_wb_stb     (data_wb_stb),
        .o_wb_we      (data_wb_we),
        .o_wb_adr     (data_wb_adr),
        .o_wb_dat     (data_wb_dat),
        .o_wb_sel     (data_wb_sel),
        .i_wb_ack     (data_wb_ack),
        .i_wb_err     (data_wb_err),
        .i_wb_rty     (data_wb_rty),
        .i_wb_dat     (i_wb_dat)
    );

    icache icache (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .o_fetch_data (o_fetch_data),
        .o_fetch_ack  (o_fetch_ack),
        .o_wb_cyc     (fetch_wb_cyc),
        .o_wb_stb     (fetch_wb_stb),
        .o_wb_we      (fetch_wb_we),
        .o_wb_adr     (fetch_wb_adr),
        .o_wb_sel     (fetch_wb_sel),
        .i_wb_ack     (fetch_wb_ack),
        .i_wb_dat     (i_wb_dat)
    );

    // The cache never writes, so its bus data is tied low
    wb_priority_arbiter wb_arb (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wb0_cyc (data_wb_cyc),
        .i_wb0_stb (data_wb_stb),
        .i_wb0_we  (data_wb_we),
        .i_wb0_adr (data_wb_adr),
        .i_wb0_dat (data_wb_dat),
        .i_wb0_sel (data_wb_sel),
        .o_wb0_ack (data_wb_ack),
        .o_wb0_err (data_wb_err),
        .o_wb0_rty (data_wb_rty),
        .i_wb1_cyc (fetch_wb_cyc),
        .i_wb1_stb (fetch_wb_stb),
        .i_wb1_we  (fetch_wb_we),
        .i_wb1_adr (fetch_wb_adr),
        .i_wb1_dat ({mem_pkg::WB_DATA_W{1'b0}}),
        .i_wb1_sel (fetch_wb_sel),
        .o_wb1_ack (fetch_wb_ack),
        .o_wb1_err (),
        .o_wb1_rty (),
        .o_wb_cyc  (o_wb_cyc),
        .o_wb_stb  (o_wb_stb),
        .o_wb_we   (o_wb_we),
        .o_wb_adr  (o_wb_adr),
        .o_wb_dat  (o_wb_dat),
        .o_wb_sel  (o_wb_sel),
        .i_wb_ack  (i_wb_ack),
        .i_wb_err  (i_wb_err),
        .i_wb_rty  (i_wb_rty)
    );

endmodule

`default_nettype wire

//--- hdl/wb_data_master.sv
`timescale 1ns/100ps
`default_nettype none

module wb_data_master (
    input  wire                              i_clk,
    input  wire                              i_arst_n,

    input  wire                              i_data_req,
    input  wire                              i_data_we,
    input  wire  [mem_pkg::RW-1:0]           i_data_addr,
    input  wire  [mem_pkg::RW-1:0]           i_data_wdata,
    output logic [mem_pkg::RW-1:0]           o_data_rdata,
    output logic                             o_data_ack,
    output logic                             o_data_err,

    output logic                             o_wb_cyc,
    output logic                             o_wb_stb,
    output logic                             o_wb_we,
    output logic [mem_pkg::WB_ADDR_W-1:0]    o_wb_adr,
    output logic [mem_pkg::WB_DATA_W-1:0]    o_wb_dat,
    output logic [mem_pkg::WB_SEL_BITS-1:0]  o_wb_sel,
    input  wire                              i_wb_ack,
    input  wire                              i_wb_err,
    input  wire                              i_wb_rty,
    input  wire  [mem_pkg::WB_DATA_W-1:0]    i_wb_dat
);

    logic start;
    logic done;
    logic retry;

    // cyc high with stb low is the one-cycle pause after rty
    assign start = i_data_req && !o_data_ack && !o_wb_cyc;
    assign done = o_wb_stb && (i_wb_ack || i_wb_err);
    assign retry = o_wb_stb && i_wb_rty && !done;

    assign o_wb_sel = {mem_pkg::WB_SEL_BITS{1'b1}};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we <= 1'b0;
            o_data_ack <= 1'b0;
            o_data_err <= 1'b0;
        end else begin
            o_data_ack <= done;
            o_data_err <= o_wb_stb && i_wb_err;
            if (start) begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                o_wb_we <= i_data_we;
            end else if (done) begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_we <= 1'b0;
            end else if (retry) begin
                o_wb_stb <= 1'b0;
            end else if (o_wb_cyc && !o_wb_stb) begin
                o_wb_stb <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            o_wb_adr <= {{mem_pkg::WB_ADDR_PAD{1'b0}}, i_data_addr};
            o_wb_dat <= i_data_wdata;
        end
        if (done && !o_wb_we) begin
            o_data_rdata <= i_wb_dat;
        end
    end

    a_err_with_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_data_err |-> o_data_ack);

endmodule

`default_nettype wire

//--- hdl/wb_priority_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_priority_arbiter (
    input  wire                              i_clk,
    input  wire                              i_arst_n,

    // Data master has the higher priority
    input  wire                              i_wb0_cyc,
    input  wire                              i_wb0_stb,
    input  wire                              i_wb0_we,
    input  wire  [mem_pkg::WB_ADDR_W-1:0]    i_wb0_adr,
    input  wire  [mem_pkg::WB_DATA_W-1:0]    i_wb0_dat,
    input  wire  [mem_pkg::WB_SEL_BITS-1:0]  i_wb0_sel,
    output logic                             o_wb0_ack,
    output logic                             o_wb0_err,
    output logic                             o_wb0_rty,

    // Instruction cache
    input  wire                              i_wb1_cyc,
    input  wire                              i_wb1_stb,
    input  wire                              i_wb1_we,
    input  wire  [mem_pkg::WB_ADDR_W-1:0]    i_wb1_adr,
    input  wire  [mem_pkg::WB_DATA_W-1:0]    i_wb1_dat,
    input  wire  [mem_pkg::WB_SEL_BITS-1:0]  i_wb1_sel,
    output logic                             o_wb1_ack,
    output logic                             o_wb1_err,
    output logic                             o_wb1_rty,

    output logic                             o_wb_cyc,
    output logic                             o_wb_stb,
    output logic                             o_wb_we,
    output logic [mem_pkg::WB_ADDR_W-1:0]    o_wb_adr,
    output logic [mem_pkg::WB_DATA_W-1:0]    o_wb_dat,
    output logic [mem_pkg::WB_SEL_BITS-1:0]  o_wb_sel,
    input  wire                              i_wb_ack,
    input  wire                              i_wb_err,
    input  wire                              i_wb_rty
);

    logic grant;
    logic owner_cyc;

    assign owner_cyc = grant ? i_wb1_cyc : i_wb0_cyc;

    // Idle bus falls back to the data master
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            grant <= 1'b0;
        end else if (!owner_cyc) begin
            grant <= !i_wb0_cyc && i_wb1_cyc;
        end
    end

    always_comb begin
        o_wb_cyc = owner_cyc;
        o_wb_stb = grant ? i_wb1_stb : i_wb0_stb;
        o_wb_we = grant ? i_wb1_we : i_wb0_we;
        o_wb_adr = grant ? i_wb1_adr : i_wb0_adr;
        o_wb_dat = grant ? i_wb1_dat : i_wb0_dat;
        o_wb_sel = grant ? i_wb1_sel : i_wb0_sel;
        o_wb0_ack = !grant && i_wb_ack;
        o_wb0_err = !grant && i_wb_err;
        o_wb0_rty = !grant && i_wb_rty;
        o_wb1_ack = grant && i_wb_ack;
        o_wb1_err = grant && i_wb_err;
        o_wb1_rty = grant && i_wb_rty;
    end

    // A response only reaches a master that is inside its own bus cycle
    a_resp0_in_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_wb0_ack || o_wb0_err || o_wb0_rty) |-> i_wb0_cyc);

    a_resp1_in_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_wb1_ack || o_wb1_err || o_wb1_rty) |-> i_wb1_cyc);

endmodule

`default_nettype wire

//--- upper_core.f
hdl/mem_pkg.sv
hdl/icache.sv
hdl/wb_data_master.sv
hdl/wb_priority_arbiter.sv
hdl/upper_core.sv
bench/wb_mem_model.sv
bench/upper_core_tb.sv
